// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert --timing -j 0
TOP       = tb_cache_top
FILELIST  = build.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// ==== build.f ====
common/cache_pkg.sv
cache/cache_arb.sv
cache/cache_rw.sv
cache/cache_ri.sv
design/cache_top.sv
verification/cache_assert.sv
verification/tb_cache_top.sv

// ==== cache/cache_arb.sv ====
`timescale 1ns/1ps

module cache_arb import cache_pkg::*; (
  input  logic                     clk,
  input  logic                     rest,
  // CPU side
  input  logic [cache_addr_w-1:0]  s0_address,
  input  logic [cache_be_w-1:0]    s0_byteenable,
  input  logic                     s0_read,
  input  logic                     s0_write,
  input  logic [cache_data_w-1:0]  s0_writedata,
  output logic                     s0_waitrequest,
  output logic [cache_data_w-1:0]  s0_readdata,
  output logic                     s0_readdatavalid,
  // Refill engine side
  input  logic [cache_addr_w-1:0]  s1_address,
  input  logic [cache_be_w-1:0]    s1_byteenable,
  input  logic                     s1_read,
  input  logic                     s1_write,
  input  logic [cache_data_w-1:0]  s1_writedata,
  input  logic                     s1_beginbursttransfer,
  input  logic [cache_burst_w-1:0] s1_burstcount,
  output logic                     s1_waitrequest,
  output logic [cache_data_w-1:0]  s1_readdata,
  output logic                     s1_readdatavalid,
  // Cache controller
  output logic [cache_addr_w-1:0]  m0_address,
  output logic [cache_be_w-1:0]    m0_byteenable,
  output logic                     m0_read,
  output logic                     m0_write,
  output logic [cache_data_w-1:0]  m0_writedata,
  input  logic                     m0_waitrequest,
  input  logic [cache_data_w-1:0]  m0_readdata,
  input  logic                     m0_readdatavalid,
  // External bus
  output logic [cache_addr_w-1:0]  m1_address,
  output logic [cache_be_w-1:0]    m1_byteenable,
  output logic                     m1_read,
  output logic                     m1_write,
  output logic [cache_data_w-1:0]  m1_writedata,
  output logic                     m1_beginbursttransfer,
  output logic [cache_burst_w-1:0] m1_burstcount,
  input  logic                     m1_waitrequest,
  input  logic [cache_data_w-1:0]  m1_readdata,
  input  logic                     m1_readdatavalid,
  output logic                     rw_bus_idle
);

  logic [3:0] count;  // Outstanding IO reads on the external bus
  logic       is_io;
  logic       bus_idle;
  logic       sel;    // 1 selects the cache side, 0 lets IO through
  logic       hold;

  assign is_io       = s0_address[cache_io_bit];
  assign bus_idle    = (count == 4'd0);
  assign rw_bus_idle = bus_idle;
  assign sel         = (m0_waitrequest || !is_io) && bus_idle;
  assign hold        = !is_io && !bus_idle;  // Cached access waits for IO reads to drain

  ////////////////////////////////////////////////////////////////////////////
  // Commands

  // The cache only sees a cached strobe the CPU can actually complete this cycle
  assign m0_address    = s0_address;
  assign m0_byteenable = s0_byteenable;
  assign m0_writedata  = s0_writedata;
  assign m0_read       = s0_read && !is_io && bus_idle && !m1_waitrequest;
  assign m0_write      = s0_write && !is_io && bus_idle && !m1_waitrequest;

  assign m1_address            = sel ? s1_address : s0_address;
  assign m1_byteenable         = sel ? s1_byteenable : s0_byteenable;
  assign m1_read               = sel ? s1_read : s0_read && !hold;
  assign m1_write              = sel ? s1_write : s0_write && !hold;
  assign m1_writedata          = sel ? s1_writedata : s0_writedata;
  assign m1_beginbursttransfer = sel && s1_beginbursttransfer;
  assign m1_burstcount         = sel ? s1_burstcount : '0;

  assign s0_waitrequest = m0_waitrequest || m1_waitrequest || hold;
  assign s1_waitrequest = m1_waitrequest;

  ////////////////////////////////////////////////////////////////////////////
  // Responses

  assign s0_readdata      = sel ? m0_readdata : m1_readdata;
  assign s0_readdatavalid = sel ? m0_readdatavalid : m1_readdatavalid;
  assign s1_readdata      = m1_readdata;
  assign s1_readdatavalid = m1_readdatavalid && sel;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      count <= 4'd0;
    end else if (!sel) begin
      case ({m1_read && !m1_waitrequest, m1_readdatavalid})
        2'b10: if (count != 4'd15) count <= count + 4'd1;
        2'b01: if (count != 4'd0) count <= count - 4'd1;
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== cache/cache_ri.sv ====
`timescale 1ns/1ps

module cache_ri import cache_pkg::*; #(
  parameter int line_words = 4
) (
  input  logic                          clk,
  input  logic                          rest,
  input  logic                          refill_req,
  input  logic [cache_addr_w-1:0]       refill_addr,
  output logic                          refill_word_valid,
  output logic [cache_data_w-1:0]       refill_word,
  output logic [$clog2(line_words)-1:0] refill_index,
  output logic                          refill_done,
  input  logic                          wr_req,
  input  logic [cache_addr_w-1:0]       wr_addr,
  input  logic [cache_data_w-1:0]       wr_data,
  input  logic [cache_be_w-1:0]         wr_be,
  output logic                          wr_done,
  output logic [cache_addr_w-1:0]       address,
  output logic [cache_be_w-1:0]         byteenable,
  output logic                          read,
  output logic                          write,
  output logic [cache_data_w-1:0]       writedata,
  output logic                          beginbursttransfer,
  output logic [cache_burst_w-1:0]      burstcount,
  input  logic                          waitrequest,
  input  logic [cache_data_w-1:0]       readdata,
  input  logic                          readdatavalid
);

  localparam int cnt_w = $clog2(line_words);
  localparam logic [cnt_w-1:0] last_idx = cnt_w'(line_words - 1);

  typedef enum logic [2:0] {
    s_idle,
    s_rcmd,
    s_rdata,
    s_rdone,
    s_wcmd
  } ri_state_t;

  ri_state_t        state;
  logic             first_cmd;  // First cycle of the burst command
  logic [cnt_w-1:0] word_cnt;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state     <= s_idle;
      first_cmd <= 1'b0;
      word_cnt  <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (refill_req) begin
            state     <= s_rcmd;
            first_cmd <= 1'b1;
            word_cnt  <= '0;
          end else if (wr_req) begin
            state <= s_wcmd;
          end
        end
        s_rcmd: begin
          first_cmd <= 1'b0;
          if (!waitrequest) state <= s_rdata;
        end
        s_rdata: begin
          if (readdatavalid) begin
            word_cnt <= word_cnt + cnt_w'(1);
            if (word_cnt == last_idx) state <= s_rdone;
          end
        end
        s_rdone: state <= s_idle;  // Lets the controller drop refill_req
        s_wcmd:  if (!waitrequest) state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus command held by the state under waitrequest

  assign read               = (state == s_rcmd);
  assign write              = (state == s_wcmd);
  assign beginbursttransfer = read && first_cmd;
  assign address            = write ? wr_addr : refill_addr;
  assign byteenable         = write ? wr_be : '1;
  assign writedata          = wr_data;
  assign burstcount         = write ? cache_burst_w'(1) : cache_burst_w'(line_words);

  assign refill_word_valid = (state == s_rdata) && readdatavalid;
  assign refill_word       = readdata;
  assign refill_index      = word_cnt;
  assign refill_done       = (state == s_rdone);
  assign wr_done           = write && !waitrequest;

endmodule

// ==== cache/cache_rw.sv ====
`timescale 1ns/1ps

module cache_rw import cache_pkg::*; #(
  parameter int line_words = 4,
  parameter int sets       = 16
) (
  input  logic                          clk,
  input  logic                          rest,
  input  logic [cache_addr_w-1:0]       address,
  input  logic [cache_be_w-1:0]         byteenable,
  input  logic                          read,
  input  logic                          write,
  input  logic [cache_data_w-1:0]       writedata,
  output logic                          waitrequest,
  output logic [cache_data_w-1:0]       readdata,
  output logic                          readdatavalid,
  input  logic                          rw_bus_idle,
  output logic                          refill_req,
  output logic [cache_addr_w-1:0]       refill_addr,
  input  logic                          refill_word_valid,
  input  logic [cache_data_w-1:0]       refill_word,
  input  logic [$clog2(line_words)-1:0] refill_index,
  input  logic                          refill_done,
  output logic                          wr_req,
  output logic [cache_addr_w-1:0]       wr_addr,
  output logic [cache_data_w-1:0]       wr_data,
  output logic [cache_be_w-1:0]         wr_be,
  input  logic                          wr_done
);

  localparam int off_w = $clog2(line_words);
  localparam int idx_w = $clog2(sets);
  localparam int tag_w = cache_addr_w - idx_w - off_w - 2;

  typedef enum logic [1:0] {
    s_idle,
    s_fill,
    s_wr,
    s_resp
  } rw_state_t;

  rw_state_t         state;
  logic [tag_w-1:0]  tag_mem [sets];
  logic [sets-1:0]   valid;
  logic [cache_data_w-1:0] data_mem [sets*line_words];

  logic [tag_w-1:0]  tag;
  logic [idx_w-1:0]  idx;
  logic [off_w-1:0]  word;
  logic [idx_w-1:0]  fill_idx;
  logic              is_io;
  logic              hit;
  logic              rd_hit;
  logic              rd_miss;
  logic              wr_start;

  assign tag      = address[cache_addr_w-1 -: tag_w];
  assign idx      = address[off_w+2 +: idx_w];
  assign word     = address[2 +: off_w];
  assign fill_idx = refill_addr[off_w+2 +: idx_w];
  assign is_io    = address[cache_io_bit];
  assign hit      = valid[idx] && (tag_mem[idx] == tag);

  // IO addresses never touch the arrays
  assign rd_hit   = (state == s_idle) && read && !is_io && hit;
  assign rd_miss  = (state == s_idle) && read && !is_io && !hit && rw_bus_idle;
  assign wr_start = (state == s_idle) && write && !is_io && rw_bus_idle;

  assign refill_req    = (state == s_fill);
  assign wr_req        = (state == s_wr);
  assign readdatavalid = (state == s_resp);

  // Stays high in s_resp so the arbiter keeps routing the hit data to the CPU
  always_comb begin
    case (state)
      s_idle:  waitrequest = !is_io && (write || (read && !hit));
      s_wr:    waitrequest = !wr_done;  // The write completes with the bus
      default: waitrequest = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state <= s_idle;
      valid <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (rd_hit) state <= s_resp;
          else if (rd_miss) state <= s_fill;
          else if (wr_start) state <= s_wr;
        end
        s_fill: begin
          if (refill_done) begin
            valid[fill_idx] <= 1'b1;
            state           <= s_idle;
          end
        end
        s_wr: if (wr_done) state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arrays and request payload

  always_ff @(posedge clk) begin
    if (rd_hit) readdata <= data_mem[{idx, word}];
    if (rd_miss) refill_addr <= {address[cache_addr_w-1:off_w+2], {(off_w+2){1'b0}}};
    if (wr_start) begin
      wr_addr <= address;
      wr_data <= writedata;
      wr_be   <= byteenable;
    end
    if (state == s_fill && refill_word_valid) data_mem[{fill_idx, refill_index}] <= refill_word;
    if (state == s_fill && refill_done) tag_mem[fill_idx] <= refill_addr[cache_addr_w-1 -: tag_w];
    // Write hit merges into the line, a write miss leaves the arrays alone
    if (wr_start && hit) begin
      for (int b = 0; b < cache_be_w; b++) begin
        if (byteenable[b]) data_mem[{idx, word}][8*b +: 8] <= writedata[8*b +: 8];
      end
    end
  end

endmodule

// ==== common/cache_pkg.sv ====
package cache_pkg;

  localparam int cache_addr_w  = 32;
  localparam int cache_data_w  = 32;
  localparam int cache_be_w    = 4;
  localparam int cache_burst_w = 4;
  localparam int cache_io_bit  = 31;  // Addresses with this bit set bypass the cache

endpackage

// ==== design/cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
  parameter int line_words = 4,
  parameter int sets       = 16
) (
  input  logic                     clk,
  input  logic                     rest,
  input  logic [cache_addr_w-1:0]  cpu_address,
  input  logic [cache_be_w-1:0]    cpu_byteenable,
  input  logic                     cpu_read,
  input  logic                     cpu_write,
  input  logic [cache_data_w-1:0]  cpu_writedata,
  output logic                     cpu_waitrequest,
  output logic [cache_data_w-1:0]  cpu_readdata,
  output logic                     cpu_readdatavalid,
  output logic [cache_addr_w-1:0]  bus_address,
  output logic [cache_be_w-1:0]    bus_byteenable,
  output logic                     bus_read,
  output logic                     bus_write,
  output logic [cache_data_w-1:0]  bus_writedata,
  output logic                     bus_beginbursttransfer,
  output logic [cache_burst_w-1:0] bus_burstcount,
  input  logic                     bus_waitrequest,
  input  logic [cache_data_w-1:0]  bus_readdata,
  input  logic                     bus_readdatavalid
);

  // Arbiter to cache controller
  logic [cache_addr_w-1:0]  rw_address;
  logic [cache_be_w-1:0]    rw_byteenable;
  logic                     rw_read;
  logic                     rw_write;
  logic [cache_data_w-1:0]  rw_writedata;
  logic                     rw_waitrequest;
  logic [cache_data_w-1:0]  rw_readdata;
  logic                     rw_readdatavalid;
  logic                     rw_bus_idle;

  // Refill engine to arbiter
  logic [cache_addr_w-1:0]  ri_address;
  logic [cache_be_w-1:0]    ri_byteenable;
  logic                     ri_read;
  logic                     ri_write;
  logic [cache_data_w-1:0]  ri_writedata;
  logic                     ri_beginbursttransfer;
  logic [cache_burst_w-1:0] ri_burstcount;
  logic                     ri_waitrequest;
  logic [cache_data_w-1:0]  ri_readdata;
  logic                     ri_readdatavalid;

  // Controller requests
  logic                          refill_req;
  logic [cache_addr_w-1:0]       refill_addr;
  logic                          refill_word_valid;
  logic [cache_data_w-1:0]       refill_word;
  logic [$clog2(line_words)-1:0] refill_index;
  logic                          refill_done;
  logic                          wr_req;
  logic [cache_addr_w-1:0]       wr_addr;
  logic [cache_data_w-1:0]       wr_data;
  logic [cache_be_w-1:0]         wr_be;
  logic                          wr_done;

  ////////////////////////////////////////////////////////////////////////////

  cache_arb arb0 (
    .clk                   (clk),
    .rest                  (rest),
    .s0_address            (cpu_address),
    .s0_byteenable         (cpu_byteenable),
    .s0_read               (cpu_read),
    .s0_write              (cpu_write),
    .s0_writedata          (cpu_writedata),
    .s0_waitrequest        (cpu_waitrequest),
    .s0_readdata           (cpu_readdata),
    .s0_readdatavalid      (cpu_readdatavalid),
    .s1_address            (ri_address),
    .s1_byteenable         (ri_byteenable),
    .s1_read               (ri_read),
    .s1_write              (ri_write),
    .s1_writedata          (ri_writedata),
    .s1_beginbursttransfer (ri_beginbursttransfer),
    .s1_burstcount         (ri_burstcount),
    .s1_waitrequest        (ri_waitrequest),
    .s1_readdata           (ri_readdata),
    .s1_readdatavalid      (ri_readdatavalid),
    .m0_address            (rw_address),
    .m0_byteenable         (rw_byteenable),
    .m0_read               (rw_read),
    .m0_write              (rw_write),
    .m0_writedata          (rw_writedata),
    .m0_waitrequest        (rw_waitrequest),
    .m0_readdata           (rw_readdata),
    .m0_readdatavalid      (rw_readdatavalid),
    .m1_address            (bus_address),
    .m1_byteenable         (bus_byteenable),
    .m1_read               (bus_read),
    .m1_write              (bus_write),
    .m1_writedata          (bus_writedata),
    .m1_beginbursttransfer (bus_beginbursttransfer),
    .m1_burstcount         (bus_burstcount),
    .m1_waitrequest        (bus_waitrequest),
    .m1_readdata           (bus_readdata),
    .m1_readdatavalid      (bus_readdatavalid),
    .rw_bus_idle           (rw_bus_idle)
  );

  cache_rw #(
    .line_words (line_words),
    .sets       (sets)
  ) rw0 (
    .clk               (clk),
    .rest              (rest),
    .address           (rw_address),
    .byteenable        (rw_byteenable),
    .read              (rw_read),
    .write             (rw_write),
    .writedata         (rw_writedata),
    .waitrequest       (rw_waitrequest),
    .readdata          (rw_readdata),
    .readdatavalid     (rw_readdatavalid),
    .rw_bus_idle       (rw_bus_idle),
    .refill_req        (refill_req),
    .refill_addr       (refill_addr),
    .refill_word_valid (refill_word_valid),
    .refill_word       (refill_word),
    .refill_index      (refill_index),
    .refill_done       (refill_done),
    .wr_req            (wr_req),
    .wr_addr           (wr_addr),
    .wr_data           (wr_data),
    .wr_be             (wr_be),
    .wr_done           (wr_done)
  );

  cache_ri #(
    .line_words (line_words)
  ) ri0 (
    .clk                (clk),
    .rest               (rest),
    .refill_req         (refill_req),
    .refill_addr        (refill_addr),
    .refill_word_valid  (refill_word_valid),
    .refill_word        (refill_word),
    .refill_index       (refill_index),
    .refill_done        (refill_done),
    .wr_req             (wr_req),
    .wr_addr            (wr_addr),
    .wr_data            (wr_data),
    .wr_be              (wr_be),
    .wr_done            (wr_done),
    .address            (ri_address),
    .byteenable         (ri_byteenable),
    .read               (ri_read),
    .write              (ri_write),
    .writedata          (ri_writedata),
    .beginbursttransfer (ri_beginbursttransfer),
    .burstcount         (ri_burstcount),
    .waitrequest        (ri_waitrequest),
    .readdata           (ri_readdata),
    .readdatavalid      (ri_readdatavalid)
  );

endmodule

// ==== verification/cache_assert.sv ====
`timescale 1ns/1ps

module cache_assert import cache_pkg::*; (
  input logic                     clk,
  input logic                     rest,
  input logic [cache_addr_w-1:0]  bus_address,
  input logic                     bus_read,
  input logic                     bus_write,
  input logic                     bus_waitrequest,
  input logic                     bus_beginbursttransfer,
  input logic [cache_burst_w-1:0] bus_burstcount,
  input logic                     cpu_read,
  input logic                     cpu_waitrequest,
  input logic                     cpu_readdatavalid
);

  int pending;  // Accepted CPU reads still waiting for data

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) pending <= 0;
    else pending <= pending + int'(cpu_read && !cpu_waitrequest) - int'(cpu_readdatavalid);
  end

  cmd_stable: assert property (@(posedge clk) disable iff (!rest)
    (bus_read || bus_write) && bus_waitrequest |=>
      $stable(bus_address) && $stable(bus_read) && $stable(bus_write) && $stable(bus_burstcount))
    else $error("bus command changed under waitrequest");

  burst_nonzero: assert property (@(posedge clk) disable iff (!rest)
    bus_beginbursttransfer |-> bus_burstcount != 0)
    else $error("begin-burst with a zero burst count");

  no_stray_data: assert property (@(posedge clk) disable iff (!rest)
    cpu_readdatavalid |-> pending != 0)
    else $error("CPU read data with no accepted read");

endmodule

bind cache_top cache_assert asrt0 (.*);

// ==== verification/tb_cache_top.sv ====
`timescale 1ns/1ps

module tb_cache_top import cache_pkg::*; ();

  localparam int line_words = 4;
  localparam int sets       = 16;
  localparam int max_wait   = 400;  // Cycles any single wait may take

  logic                     clk;
  logic                     rest;
  logic [cache_addr_w-1:0]  cpu_address;
  logic [cache_be_w-1:0]    cpu_byteenable;
  logic                     cpu_read;
  logic                     cpu_write;
  logic [cache_data_w-1:0]  cpu_writedata;
  logic                     cpu_waitrequest;
  logic [cache_data_w-1:0]  cpu_readdata;
  logic                     cpu_readdatavalid;
  logic [cache_addr_w-1:0]  bus_address;
  logic [cache_be_w-1:0]    bus_byteenable;
  logic                     bus_read;
  logic                     bus_write;
  logic [cache_data_w-1:0]  bus_writedata;
  logic                     bus_beginbursttransfer;
  logic [cache_burst_w-1:0] bus_burstcount;
  logic                     bus_waitrequest;
  logic [cache_data_w-1:0]  bus_readdata;
  logic                     bus_readdatavalid;

  logic [31:0] mem [logic [31:0]];     // External memory keyed by word address
  logic [31:0] shadow [logic [31:0]];  // What the CPU expects to see
  logic [31:0] exp_q [$];
  logic [31:0] resp_data [$];
  int          resp_time [$];
  logic [31:0] exp_word;
  logic [31:0] last_addr;
  logic [31:0] last_data;
  logic [3:0]  last_be;
  logic [3:0]  last_bc;
  int          cyc;
  int          n_rd;
  int          n_wr;
  int          n_bb;
  int          errors;
  int          tests;
  int          failed;

  cache_top #(.line_words(line_words), .sets(sets)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] scramble(input logic [31:0] waddr);
    return (waddr * 32'h9e3779b1) ^ {waddr[15:0], waddr[31:16]} ^ 32'h5a5a0f0f;
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                        input logic [3:0] be);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) if (be[b]) r[8*b +: 8] = data[8*b +: 8];
    return r;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] w;
    w = {2'b00, addr[31:2]};
    if (mem.exists(w)) return mem[w];
    return scramble(w);
  endfunction

  // Expected read value from the CPU's view of memory
  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    logic [31:0] w;
    w = {2'b00, addr[31:2]};
    if (shadow.exists(w)) return shadow[w];
    return scramble(w);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // External memory with random back-pressure

  always @(posedge clk) begin : bus_model
    int t;
    int n;
    cyc++;
    if (!rest) begin
      bus_waitrequest   <= 1'b0;
      bus_readdatavalid <= 1'b0;
    end else begin
      if (bus_read && bus_beginbursttransfer) n_bb++;
      if (bus_read && !bus_waitrequest) begin
        n_rd++;
        last_addr = bus_address;
        last_bc   = bus_burstcount;
        n = (bus_burstcount == 0) ? 1 : int'(bus_burstcount);
        t = cyc + 2;
        if (resp_time.size() > 0 && resp_time[$] >= t) t = resp_time[$] + 1;
        for (int i = 0; i < n; i++) begin
          resp_data.push_back(mem_word(bus_address + 32'(4 * i)));
          resp_time.push_back(t + i);
        end
      end
      if (bus_write && !bus_waitrequest) begin
        n_wr++;
        last_addr = bus_address;
        last_data = bus_writedata;
        last_be   = bus_byteenable;
        last_bc   = bus_burstcount;
        mem[{2'b00, bus_address[31:2]}] = merge(mem_word(bus_address), bus_writedata,
                                                bus_byteenable);
      end
      if (resp_time.size() > 0 && resp_time[0] <= cyc) begin
        bus_readdatavalid <= 1'b1;
        bus_readdata      <= resp_data.pop_front();
        void'(resp_time.pop_front());
      end else begin
        bus_readdatavalid <= 1'b0;
      end
      bus_waitrequest <= ($urandom % 3) == 0;
    end
  end

  always @(negedge clk) begin
    if (rest && cpu_readdatavalid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Fail at %0t: read data returned with no read pending", $time);
      end else begin
        exp_word = exp_q.pop_front();
        if (cpu_readdata !== exp_word) begin
          errors++;
          $display("Fail at %0t: read data %h, expected %h", $time, cpu_readdata, exp_word);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // CPU side

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("Something failed");
    $finish;
  endtask

  task automatic cpu_access(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    cpu_address    <= addr;
    cpu_byteenable <= be;
    cpu_writedata  <= data;
    cpu_read       <= !wr;
    cpu_write      <= wr;
    @(negedge clk);
    while (cpu_waitrequest) begin
      waited++;
      if (waited > max_wait) abort_run("the CPU access was never accepted");
      @(negedge clk);
    end
    @(posedge clk);  // Accepted on this edge
    cpu_read  <= 1'b0;
    cpu_write <= 1'b0;
    if (wr) shadow[{2'b00, addr[31:2]}] = merge(ref_read(addr), data, be);
    else exp_q.push_back(ref_read(addr));
    if (!wr && !addr[cache_io_bit]) begin
      @(negedge clk);
      if (!cpu_readdatavalid) begin
        errors++;
        $display("Fail at %0t: cached read data not one cycle after acceptance", $time);
      end
    end
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > max_wait) abort_run("read data never came back");
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic expect_true(input logic ok, input string what);
    if (!ok) begin
      errors++;
      $display("Fail at %0t: %s", $time, what);
    end
  endtask

  task automatic close_test(input string name, input int e0);
    tests++;
    if (errors > e0) begin
      failed++;
      $display("%s: failed with %0d errors", name, errors - e0);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  initial begin : main
    int e0;
    int r0;
    int w0;
    int b0;
    logic [31:0] a;
    void'($urandom(32'ha80a9244));
    rest           = 1'b0;
    cpu_address    = '0;
    cpu_byteenable = '0;
    cpu_read       = 1'b0;
    cpu_write      = 1'b0;
    cpu_writedata  = '0;
    bus_waitrequest   = 1'b0;
    bus_readdata      = '0;
    bus_readdatavalid = 1'b0;
    repeat (2) @(posedge clk);
    rest <= 1'b1;

    e0 = errors;
    r0 = n_rd;
    b0 = n_bb;
    cpu_access(1'b0, 32'h104, 4'hf, 32'h0);
    drain_reads();
    expect_true(n_rd == r0 + 1, "cold miss did not issue exactly one bus read");
    expect_true(last_addr == 32'h100 && last_bc == 4, "refill burst address or count wrong");
    expect_true(n_bb == b0 + 1, "refill did not raise begin-burst exactly once");
    close_test("cold read miss", e0);

    e0 = errors;
    r0 = n_rd;
    cpu_access(1'b0, 32'h100, 4'hf, 32'h0);
    cpu_access(1'b0, 32'h108, 4'hf, 32'h0);
    cpu_access(1'b0, 32'h10c, 4'hf, 32'h0);
    drain_reads();
    expect_true(n_rd == r0, "read hit went out to the bus");
    close_test("read hit", e0);

    e0 = errors;
    w0 = n_wr;
    cpu_access(1'b1, 32'h108, 4'b0101, 32'hdeadbeef);
    cpu_access(1'b0, 32'h108, 4'hf, 32'h0);
    drain_reads();
    expect_true(n_wr == w0 + 1, "write hit did not issue one bus write");
    expect_true(last_addr == 32'h108 && last_data == 32'hdeadbeef && last_be == 4'b0101,
                "write-through command wrong");
    close_test("write-through", e0);

    e0 = errors;
    w0 = n_wr;
    cpu_access(1'b1, 32'h2004, 4'hf, 32'h12345678);
    r0 = n_rd;
    cpu_access(1'b0, 32'h2004, 4'hf, 32'h0);
    drain_reads();
    expect_true(n_wr == w0 + 1, "write miss did not reach the bus");
    expect_true(n_rd == r0 + 1, "read after write miss did not refill");
    close_test("write miss no allocate", e0);

    e0 = errors;
    r0 = n_rd;
    w0 = n_wr;
    b0 = n_bb;
    cpu_access(1'b0, 32'h80000040, 4'hf, 32'h0);
    @(negedge clk);
    expect_true(last_bc == 0, "IO read had a nonzero burst count");
    cpu_access(1'b0, 32'h80000040, 4'hf, 32'h0);
    @(negedge clk);
    expect_true(last_bc == 0, "IO read had a nonzero burst count");
    cpu_access(1'b1, 32'h80000044, 4'b0011, 32'hcafef00d);
    @(negedge clk);
    expect_true(last_bc == 0, "IO write had a nonzero burst count");
    cpu_access(1'b0, 32'h80000044, 4'hf, 32'h0);
    drain_reads();
    expect_true(n_rd == r0 + 3 && n_wr == w0 + 1, "IO accesses not all seen on the bus");
    expect_true(last_bc == 0, "IO read had a nonzero burst count");
    expect_true(n_bb == b0, "IO access raised begin-burst");
    close_test("IO bypass", e0);

    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      if ($urandom % 4 == 0) a = 32'h80000000 | ($urandom & 32'hfc);
      else a = $urandom & 32'h3fc;  // Four times the cache size, so lines alias
      cpu_access(1'(($urandom % 2)), a, 4'(($urandom % 15) + 1), $urandom);
    end
    drain_reads();
    close_test("random mix", e0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
